// File: sim.f
+incdir+src
src/booth_pkg.sv
src/booth_controller.sv
src/step_counter.sv
src/booth_datapath.sv
src/booth_multiplier.sv
sim/booth_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sim.f \
    --top-module booth_tb \
    -o booth_sim

./obj_dir/booth_sim | tee sim.log

if grep -q "Test passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi

// File: sim/booth_tb.sv
`timescale 1ns/1ps
`include "booth_config.svh"

module booth_tb;

    localparam int W       = `BOOTH_WIDTH;
    localparam int TIMEOUT = 100;

    logic                clk;
    logic                rst;
    logic                start;
    logic signed [W-1:0] multiplicand;
    logic signed [W-1:0] multiplier;
    logic                busy;
    logic                done;
    logic [2*W-1:0]      product;

    int errors;
    int checks;

    booth_multiplier dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .busy         (busy),
        .done         (done),
        .product      (product)
    );

    always #5 clk = ~clk;

    // Signed product of the sign-extended operands in 2*W bits
    function automatic logic [2*W-1:0] ref_product(input logic signed [W-1:0] a,
                                                   input logic signed [W-1:0] b);
        logic signed [2*W-1:0] a_ext;
        logic signed [2*W-1:0] b_ext;
        a_ext = $signed({{W{a[W-1]}}, a});
        b_ext = $signed({{W{b[W-1]}}, b});
        return a_ext * b_ext;
    endfunction

    task automatic check_value(input string name, input logic [2*W-1:0] got,
                               input logic [2*W-1:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              input int edge_num);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s got 0x%h, expected 0x%h after edge %0d",
                     name, got, exp, edge_num);
        end
    endtask

    // All tasks start and end just after a falling edge
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (busy)
        begin
            errors++;
            $display("Timeout: DUT still busy after %0d cycles", TIMEOUT);
        end
    endtask

    task automatic wait_done(output bit ok);
        int n;
        n = 0;
        while (!done && n < TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        ok = done;
        if (!done)
        begin
            errors++;
            $display("Timeout: no done pulse within %0d cycles, controller in %s",
                     TIMEOUT, dut.u_controller.state.name());
        end
    endtask

    // Operands stay on the inputs until the load edge has passed
    task automatic issue_start(input logic signed [W-1:0] a, input logic signed [W-1:0] b);
        multiplicand = a;
        multiplier   = b;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic run_product(input logic signed [W-1:0] a, input logic signed [W-1:0] b);
        bit ok;
        wait_idle();
        issue_start(a, b);
        wait_done(ok);
        if (ok)
        begin
            check_value("product", product, ref_product(a, b));
        end
    endtask

    task automatic corner_products();
        run_product(16'sh0000, 16'sh3039);
        run_product(-16'sd7, 16'sh0000);
        run_product(16'sd1, -16'sd1);
        run_product(-16'sd1, -16'sd1);
        run_product(16'sh8000, 16'sh8000);
        check_value("product", product, 32'h4000_0000);
        run_product(16'sh7fff, 16'sh8000);
        run_product(16'sh8000, 16'sh7fff);
        // Alternating bit patterns
        run_product(16'sh5555, 16'shaaaa);
        run_product(16'shaaaa, 16'shaaaa);
        run_product(16'sh5555, 16'sh5555);
        run_product(16'shaaaa, 16'sh5555);
    endtask

    task automatic random_products();
        logic signed [W-1:0] a;
        logic signed [W-1:0] b;
        for (int i = 0; i < 200; i++)
        begin
            a = W'($urandom);
            b = W'($urandom);
            run_product(a, b);
        end
    endtask

    task automatic latency_and_flags();
        logic signed [W-1:0] a;
        logic signed [W-1:0] b;
        a = 16'sh1234;
        b = -16'sd321;
        wait_idle();
        multiplicand = a;
        multiplier   = b;
        start        = 1'b1;
        // Edge 0 samples start and done belongs to the cycle after edge W+1
        for (int k = 0; k <= W + 3; k++)
        begin
            @(negedge clk);
            start = 1'b0;
            check_flag("done", done, (k == W + 1), k);
            check_flag("busy", busy, (k <= W + 1), k);
            if (k == W + 1)
            begin
                check_value("product", product, ref_product(a, b));
            end
        end
    endtask

    task automatic start_while_busy();
        bit ok;
        int extra;
        logic signed [W-1:0] a1;
        logic signed [W-1:0] b1;
        a1    = -16'sd1500;
        b1    = 16'sd2711;
        extra = 0;
        wait_idle();
        issue_start(a1, b1);
        repeat (6) @(negedge clk);
        // Second request mid-run with other operands
        issue_start(16'sh7001, -16'sd9);
        wait_done(ok);
        if (ok)
        begin
            check_value("product", product, ref_product(a1, b1));
        end
        for (int i = 0; i < 30; i++)
        begin
            @(negedge clk);
            if (done)
            begin
                extra++;
            end
        end
        check_value("done pulse count", 1 + extra, 1);
        check_flag("busy", busy, 1'b0, -1);
        check_value("product", product, ref_product(a1, b1));
    endtask

    task automatic reset_recovery();
        wait_idle();
        issue_start(16'sh2222, 16'sh0f0f);
        repeat (7) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        check_flag("busy", busy, 1'b0, -1);
        check_flag("done", done, 1'b0, -1);
        check_value("product", product, '0);
        rst = 1'b1;
        @(negedge clk);
        run_product(-16'sd4321, 16'sd77);
    endtask

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b0;
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        errors       = 0;
        checks       = 0;
        void'($urandom(32'h7318_de3b));

        repeat (16) @(negedge clk);
        check_flag("busy", busy, 1'b0, -1);
        check_flag("done", done, 1'b0, -1);
        check_value("product", product, '0);
        rst = 1'b1;
        @(negedge clk);

        corner_products();
        random_products();
        latency_and_flags();
        start_while_busy();
        reset_recovery();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src/booth_multiplier.sv
`timescale 1ns/1ps
`include "booth_config.svh"

module booth_multiplier (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic signed [`BOOTH_WIDTH-1:0] multiplicand,
    input  logic signed [`BOOTH_WIDTH-1:0] multiplier,
    output logic                          busy,
    output logic                          done,
    output logic [2*`BOOTH_WIDTH-1:0]     product
);

    booth_pkg::booth_ctrl_t ctrl;
    logic                   cnt_clear;
    logic                   cnt_en;
    logic                   last;
    logic [1:0]             booth_pair;

    booth_controller u_controller (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last       (last),
        .booth_pair (booth_pair),
        .ctrl       (ctrl),
        .cnt_clear  (cnt_clear),
        .cnt_en     (cnt_en),
        .busy       (busy),
        .done       (done)
    );

    step_counter #(
        .WIDTH     (`BOOTH_WIDTH),
        .CNT_WIDTH (`BOOTH_CNT_WIDTH)
    ) u_counter (
        .clk       (clk),
        .rst       (rst),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .last      (last)
    );

    booth_datapath #(
        .WIDTH (`BOOTH_WIDTH)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .booth_pair   (booth_pair),
        .product      (product)
    );

endmodule

// File: src/booth_datapath.sv
`timescale 1ns/1ps
`include "booth_config.svh"

module booth_datapath #(
    parameter int WIDTH = `BOOTH_WIDTH
) (
    input  logic                   clk,
    input  logic                   rst,
    input  booth_pkg::booth_ctrl_t ctrl,
    input  logic signed [WIDTH-1:0] multiplicand,
    input  logic signed [WIDTH-1:0] multiplier,
    output logic [1:0]             booth_pair,
    output logic [2*WIDTH-1:0]     product
);

    // Multiplicand register
    logic [WIDTH-1:0]   m;
    // Accumulator carries one guard bit so that subtracting
    // the most negative multiplicand cannot overflow
    logic [WIDTH:0]     a;
    logic [WIDTH-1:0]   q;
    logic               q_m1;

    logic [WIDTH:0]     m_ext;
    logic [WIDTH:0]     alu_out;
    logic [2*WIDTH:0]   shift_in;
    logic [2*WIDTH:0]   shifted;

    assign m_ext = {m[WIDTH-1], m};

    always_comb
    begin
        case (ctrl.op)
            booth_pkg::OP_ADD: alu_out = a + m_ext;
            booth_pkg::OP_SUB: alu_out = a - m_ext;
            default:           alu_out = a;
        endcase
    end

    // Arithmetic right shift of {A, Q}
    assign shift_in = {alu_out, q};
    assign shifted  = {shift_in[2*WIDTH], shift_in[2*WIDTH:1]};

    always_ff @(posedge clk)
    begin
        if (ctrl.load)
        begin
            m <= multiplicand;
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            a    <= '0;
            q    <= '0;
            q_m1 <= 1'b0;
        end
        else if (ctrl.load)
        begin
            a    <= '0;
            q    <= multiplier;
            q_m1 <= 1'b0;
        end
        else if (ctrl.step)
        begin
            a    <= shifted[2*WIDTH:WIDTH];
            q    <= shifted[WIDTH-1:0];
            // Bit shifted out of Q
            q_m1 <= shift_in[0];
        end
    end

    assign booth_pair = {q[0], q_m1};

    // Guard bit is only a sign copy once the run completes
    assign product = {a[WIDTH-1:0], q};

    a_load_step_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(ctrl.load && ctrl.step)
    );

endmodule

// File: src/step_counter.sv
`timescale 1ns/1ps
`include "booth_config.svh"

module step_counter #(
    parameter int WIDTH     = `BOOTH_WIDTH,
    parameter int CNT_WIDTH = `BOOTH_CNT_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  logic cnt_clear,
    input  logic cnt_en,
    output logic last
);

    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            count <= '0;
        end
        else if (cnt_clear)
        begin
            count <= '0;
        end
        else if (cnt_en)
        begin
            count <= count + 1'b1;
        end
    end

    // Final iteration of the run
    assign last = (count == CNT_WIDTH'(WIDTH - 1));

    // The controller leaves RUN on last, so the count tops out at WIDTH-1
    a_count_range: assert property (
        @(posedge clk) disable iff (!rst)
        cnt_en |-> (count <= CNT_WIDTH'(WIDTH - 1))
    );

endmodule

// File: src/booth_controller.sv
`timescale 1ns/1ps

module booth_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  last,
    input  logic [1:0]            booth_pair,
    output booth_pkg::booth_ctrl_t ctrl,
    output logic                  cnt_clear,
    output logic                  cnt_en,
    output logic                  busy,
    output logic                  done
);

    booth_pkg::booth_state_e state;
    booth_pkg::booth_state_e state_next;
    booth_pkg::booth_op_e    op_dec;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= booth_pkg::IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Start is only honoured from IDLE
    always_comb
    begin
        state_next = state;
        case (state)
            booth_pkg::IDLE: if (start) state_next = booth_pkg::LOAD;
            booth_pkg::LOAD: state_next = booth_pkg::RUN;
            booth_pkg::RUN:  if (last) state_next = booth_pkg::DONE;
            booth_pkg::DONE: state_next = booth_pkg::IDLE;
            default:         state_next = booth_pkg::IDLE;
        endcase
    end

    // Booth recoding of {Q0, Q-1}
    always_comb
    begin
        case (booth_pair)
            2'b10:   op_dec = booth_pkg::OP_SUB;
            2'b01:   op_dec = booth_pkg::OP_ADD;
            default: op_dec = booth_pkg::OP_HOLD;
        endcase
    end

    always_comb
    begin
        ctrl.load = (state == booth_pkg::LOAD);
        ctrl.step = (state == booth_pkg::RUN);
        ctrl.op   = (state == booth_pkg::RUN) ? op_dec : booth_pkg::OP_HOLD;
    end

    assign cnt_clear = (state == booth_pkg::LOAD);
    assign cnt_en    = (state == booth_pkg::RUN);
    assign busy      = (state != booth_pkg::IDLE);
    assign done      = (state == booth_pkg::DONE);

    // Result pulse is a single cycle
    a_done_single: assert property (
        @(posedge clk) disable iff (!rst)
        done |=> !done
    );

    // A new start mid-run never restarts the sequence
    a_start_ignored: assert property (
        @(posedge clk) disable iff (!rst)
        (start && state != booth_pkg::IDLE) |=> (state != booth_pkg::LOAD)
    );

endmodule

// File: src/booth_pkg.sv
package booth_pkg;

    // Controller sequence
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        LOAD = 2'b01,
        RUN  = 2'b10,
        DONE = 2'b11
    } booth_state_e;

    // Accumulator operation for one Booth step
    typedef enum logic [1:0] {
        OP_HOLD = 2'b00,
        OP_ADD  = 2'b01,
        OP_SUB  = 2'b10
    } booth_op_e;

    // Command from controller to datapath
    typedef struct packed {
        logic      load;
        logic      step;
        booth_op_e op;
    } booth_ctrl_t;

endpackage

// File: src/booth_config.svh
`ifndef BOOTH_CONFIG_SVH
`define BOOTH_CONFIG_SVH

// Operand width of multiplicand and multiplier
// One Booth step is taken per operand bit
`define BOOTH_WIDTH 16

// Step counter width that can count up to BOOTH_WIDTH
`define BOOTH_CNT_WIDTH 5

`endif
